/* build.f */
common/cpu_pkg.sv
decode/reg_file.sv
fetch/fetch_stage.sv
decode/decode_stage.sv
execute/execute_stage.sv
hdl/memory_stage.sv
hdl/writeback_stage.sv
hdl/cpu_core.sv
tb/cpu_assertions.sv
tb/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - common/cpu_pkg.sv
  - decode/reg_file.sv
  - fetch/fetch_stage.sv
  - decode/decode_stage.sv
  - execute/execute_stage.sv
  - hdl/memory_stage.sv
  - hdl/writeback_stage.sv
  - hdl/cpu_core.sv
  - target: test
    files:
      - tb/cpu_assertions.sv
      - tb/cpu_tb.sv

/* tb/cpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam int prog_len      = 400;
    localparam int imem_depth    = 512;
    localparam int dmem_depth    = 256;
    localparam int seed          = 84;
    localparam int start_timeout = 20;
    localparam int run_timeout   = 20000;
    localparam int idle_window   = 40;

    logic        clk = 1'b0;
    logic        reset;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_wen;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [imem_depth];
    logic [31:0] sram_dmem [dmem_depth];
    logic [31:0] model_mem [dmem_depth];
    logic [31:0] model_regs [32];
    int          last_writer [32];

    // expected register writes and stores in program order
    logic [31:0] exp_wr_pc [$];
    logic [4:0]  exp_wr_num [$];
    logic [31:0] exp_wr_data [$];
    int          exp_wr_test [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];

    int          checks [6];
    int          errors [6];
    string       test_names [6];
    logic        timed_out;
    logic        inst_pending;
    logic [31:0] inst_req_addr;
    logic        data_pending;
    logic [31:0] data_read_word;

    cpu_core dut_i (.*);

    always #10 clk = ~clk;

    task automatic compare(input int test, input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks[test]++;
        if (actual !== expected) begin
            errors[test]++;
            $display("MISMATCH %s %s expected %h actual %h", test_names[test], what,
                     expected, actual);
        end
    endtask

    task automatic report_test(input int test);
        $display("%-10s checks %0d errors %0d", test_names[test], checks[test], errors[test]);
    endtask

    function automatic logic [4:0] pick_reg();
        logic [4:0] r;
        // few registers so reuse is dense
        r = $urandom % 8;
        return r;
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return (idx * 32'h9e3779b1) ^ 32'h5a5a0000;
    endfunction

    task automatic build_program();
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        int          kind;
        for (int i = 0; i < imem_depth; i++) begin
            imem[i] = '0;
        end
        // working registers get known values first
        for (int i = 0; i < 7; i++) begin
            rt = i + 1;
            imm = $urandom;
            imem[i] = {op_addiu, 5'd0, rt, imm};
        end
        for (int i = 7; i < prog_len; i++) begin
            rs = pick_reg();
            rt = pick_reg();
            rd = pick_reg();
            imm = $urandom;
            kind = $urandom % 10;
            case (kind)
                0: fn = fn_addu;
                1: fn = fn_subu;
                2: fn = fn_and;
                3: fn = fn_or;
                4: fn = fn_xor;
                default: fn = fn_slt;
            endcase
            if (kind < 6) begin
                imem[i] = {op_special, rs, rt, rd, 5'd0, fn};
            end else if (kind == 6) begin
                imem[i] = {op_addiu, rs, rt, imm};
            end else if (kind == 7) begin
                imem[i] = {op_ori, rs, rt, imm};
            end else if (kind == 8) begin
                imem[i] = {op_lui, 5'd0, rt, imm};
            end else begin
                // small word window so loads hit earlier stores
                imm = ($urandom % 16) * 4;
                imem[i] = {(($urandom % 2) != 0) ? op_lw : op_sw, 5'd0, rt, imm};
            end
        end
    endtask

    task automatic run_model();
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] addr;
        logic [31:0] value;
        logic [4:0]  dest;
        int          test;
        bit          dep;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
            last_writer[r] = -10;
        end
        for (int i = 0; i < prog_len; i++) begin
            inst = imem[i];
            pc = reset_pc + i * 4;
            a = model_regs[inst[25:21]];
            b = model_regs[inst[20:16]];
            sext = {{16{inst[15]}}, inst[15:0]};
            addr = a + sext;
            dest = inst[20:16];
            value = '0;
            test = 2;
            // a source written by one of the three instructions before
            dep = inst[25:21] != 0 && last_writer[inst[25:21]] >= i - 3;
            case (inst[31:26])
                op_special: begin
                    dest = inst[15:11];
                    test = 1;
                    dep = dep || (inst[20:16] != 0 && last_writer[inst[20:16]] >= i - 3);
                    case (inst[5:0])
                        fn_addu: value = a + b;
                        fn_subu: value = a - b;
                        fn_and:  value = a & b;
                        fn_or:   value = a | b;
                        fn_xor:  value = a ^ b;
                        fn_slt:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: dest = '0;
                    endcase
                end
                op_addiu: value = a + sext;
                op_ori:   value = a | {16'h0000, inst[15:0]};
                op_lui:   value = {inst[15:0], 16'h0000};
                op_lw: begin
                    value = model_mem[addr[9:2]];
                    test = 4;
                end
                op_sw: begin
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                    model_mem[addr[9:2]] = b;
                    dest = '0;
                end
                default: dest = '0;
            endcase
            if (dest != 0) begin
                exp_wr_pc.push_back(pc);
                exp_wr_num.push_back(dest);
                exp_wr_data.push_back(value);
                exp_wr_test.push_back(dep ? 3 : test);
                model_regs[dest] = value;
                last_writer[dest] = i;
            end
        end
    endtask

    // ------------------------------
    // sram models with a one cycle read
    // ------------------------------
    always @(negedge clk) begin
        if (inst_pending) begin
            inst_sram_rdata = (inst_req_addr - reset_pc < imem_depth * 4) ?
                              imem[(inst_req_addr - reset_pc) >> 2] : 32'd0;
        end
        inst_pending = reset !== 1'b1 && inst_sram_en === 1'b1;
        inst_req_addr = inst_sram_addr;
    end

    always @(negedge clk) begin
        if (data_pending) begin
            data_sram_rdata = data_read_word;
        end
        data_pending = 1'b0;
        if (reset !== 1'b1 && data_sram_en === 1'b1) begin
            if (data_sram_wen != 4'b0000) begin
                sram_dmem[data_sram_addr[9:2]] = data_sram_wdata;
            end else begin
                data_read_word = sram_dmem[data_sram_addr[9:2]];
                data_pending = 1'b1;
            end
        end
    end

    // ------------------------------
    // write and store monitor
    // ------------------------------
    always @(negedge clk) begin
        int t;
        if (reset !== 1'b1 && debug_wb_rf_wen != 4'b0000) begin
            if (exp_wr_pc.size() == 0) begin
                checks[5]++;
                errors[5]++;
                $display("register write to r%0d at pc %h came after the last expected write",
                         debug_wb_rf_wnum, debug_wb_pc);
            end else begin
                t = exp_wr_test.pop_front();
                compare(t, "write_pc", exp_wr_pc.pop_front(), debug_wb_pc);
                compare(t, "write_num", exp_wr_num.pop_front(), debug_wb_rf_wnum);
                compare(t, "write_data", exp_wr_data.pop_front(), debug_wb_rf_wdata);
            end
        end
        if (reset !== 1'b1 && data_sram_en === 1'b1 && data_sram_wen != 4'b0000) begin
            if (exp_st_addr.size() == 0) begin
                checks[4]++;
                errors[4]++;
                $display("store to %h came after the last expected store", data_sram_addr);
            end else begin
                compare(4, "store_wen", 32'hf, data_sram_wen);
                compare(4, "store_addr", exp_st_addr.pop_front(), data_sram_addr);
                compare(4, "store_data", exp_st_data.pop_front(), data_sram_wdata);
            end
        end
    end

    initial begin
        int unsigned rnd;
        int          wait_cycles;
        int          total_checks;
        int          total_errors;
        int          assert_failures;
        reset = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        inst_pending = 1'b0;
        data_pending = 1'b0;
        timed_out = 1'b0;
        rnd = $urandom(seed);
        test_names = '{"reset", "alu", "immediate", "dependence", "memory", "completion"};
        for (int i = 0; i < dmem_depth; i++) begin
            sram_dmem[i] = fill_word(i * 4);
            model_mem[i] = fill_word(i * 4);
        end
        build_program();
        run_model();

        repeat (8) begin
            @(negedge clk);
            compare(0, "rf_wen_in_reset", 32'd0, debug_wb_rf_wen);
            compare(0, "inst_en_in_reset", 32'd0, inst_sram_en);
            compare(0, "data_en_in_reset", 32'd0, data_sram_en);
        end
        reset = 1'b0;

        wait_cycles = 0;
        while (inst_sram_en !== 1'b1 && wait_cycles < start_timeout) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (inst_sram_en !== 1'b1) begin
            timed_out = 1'b1;
            $display("timeout: no instruction fetch after reset was released");
        end else begin
            compare(0, "first_fetch_addr", reset_pc, inst_sram_addr);
            compare(0, "inst_wen", 32'd0, inst_sram_wen);
            compare(0, "inst_wdata", 32'd0, inst_sram_wdata);
        end
        report_test(0);

        wait_cycles = 0;
        while ((exp_wr_pc.size() != 0 || exp_st_addr.size() != 0) &&
               wait_cycles < run_timeout && !timed_out) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (exp_wr_pc.size() != 0 || exp_st_addr.size() != 0) begin
            timed_out = 1'b1;
            $display("timeout: %0d register writes and %0d stores never appeared",
                     exp_wr_pc.size(), exp_st_addr.size());
        end
        // quiet window for late extra writes
        repeat (idle_window) @(negedge clk);
        compare(5, "writes_left", 32'd0, exp_wr_pc.size());
        compare(5, "stores_left", 32'd0, exp_st_addr.size());

        total_checks = checks[0];
        total_errors = errors[0];
        for (int t = 1; t < 6; t++) begin
            report_test(t);
            total_checks += checks[t];
            total_errors += errors[t];
        end
        assert_failures = dut_i.assertions_i.failures;
        $display("tests 6 checks %0d errors %0d assertion failures %0d",
                 total_checks, total_errors, assert_failures);
        if (total_errors == 0 && assert_failures == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/cpu_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_assertions (
    input logic       clk,
    input logic       reset,
    input logic       inst_sram_en,
    input logic       data_sram_en,
    input logic [3:0] data_sram_wen,
    input logic [3:0] debug_wb_rf_wen
);

    int failures = 0;

    // write strobe only with the enable
    wen_needs_en: assert property (@(posedge clk) disable iff (reset)
        data_sram_wen != 4'b0000 |-> data_sram_en)
        else begin
            failures++;
            $error("data_sram_wen set while data_sram_en is low");
        end

    rf_wen_whole: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_wen == 4'b1111 || debug_wb_rf_wen == 4'b0000)
        else begin
            failures++;
            $error("debug_wb_rf_wen is neither all ones nor zero");
        end

    // quiet once reset has been seen for a full cycle
    quiet_in_reset: assert property (@(posedge clk)
        reset && $past(reset) |->
            !inst_sram_en && !data_sram_en && debug_wb_rf_wen == 4'b0000)
        else begin
            failures++;
            $error("an enable is active while reset is high");
        end

endmodule

bind cpu_core cpu_assertions assertions_i (.*);

`default_nettype wire

/* hdl/cpu_core.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_core (
    input  logic                     clk,
    input  logic                     reset,

    output logic                     inst_sram_en,
    output logic [3:0]               inst_sram_wen,
    output logic [cpu_pkg::xlen-1:0] inst_sram_addr,
    output logic [cpu_pkg::xlen-1:0] inst_sram_wdata,
    input  logic [cpu_pkg::xlen-1:0] inst_sram_rdata,

    output logic                     data_sram_en,
    output logic [3:0]               data_sram_wen,
    output logic [cpu_pkg::xlen-1:0] data_sram_addr,
    output logic [cpu_pkg::xlen-1:0] data_sram_wdata,
    input  logic [cpu_pkg::xlen-1:0] data_sram_rdata,

    output logic [cpu_pkg::xlen-1:0] debug_wb_pc,
    output logic [3:0]               debug_wb_rf_wen,
    output logic [4:0]               debug_wb_rf_wnum,
    output logic [cpu_pkg::xlen-1:0] debug_wb_rf_wdata
);
    import cpu_pkg::*;

    // fetch -> decode
    logic                  if_valid;
    logic [xlen-1:0]       if_pc;
    logic [xlen-1:0]       if_inst;
    logic                  id_allowin;

    // decode -> execute
    logic                  id_valid;
    logic [xlen-1:0]       id_pc;
    alu_op_t               id_alu_op;
    logic [xlen-1:0]       id_src_a;
    logic [xlen-1:0]       id_src_b;
    logic [xlen-1:0]       id_store_data;
    logic                  id_is_load;
    logic                  id_is_store;
    logic [reg_addr_w-1:0] id_wnum;
    logic                  exe_allowin;

    // execute -> memory
    logic                  exe_valid;
    logic [xlen-1:0]       exe_pc;
    logic [xlen-1:0]       exe_result;
    logic                  exe_is_load;
    logic [reg_addr_w-1:0] exe_wnum;
    logic                  mem_allowin;

    // memory -> writeback
    logic                  mem_valid;
    logic [xlen-1:0]       mem_pc;
    logic [xlen-1:0]       mem_result;
    logic                  mem_is_load;
    logic [reg_addr_w-1:0] mem_wnum;
    logic                  wb_allowin;

    // register file write from writeback
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;

    // instruction memory is read only
    assign inst_sram_wen   = 4'b0000;
    assign inst_sram_wdata = '0;

    fetch_stage fetch_i (.*);

    decode_stage decode_i (
        .wb_wnum (rf_waddr),
        .*
    );

    execute_stage execute_i (.*);

    memory_stage memory_i (.*);

    writeback_stage writeback_i (.*);

endmodule

`default_nettype wire

/* hdl/writeback_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module writeback_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           mem_valid,
    input  logic [cpu_pkg::xlen-1:0]       mem_pc,
    input  logic [cpu_pkg::xlen-1:0]       mem_result,
    input  logic                           mem_is_load,
    input  logic [cpu_pkg::reg_addr_w-1:0] mem_wnum,
    input  logic [cpu_pkg::xlen-1:0]       data_sram_rdata,
    output logic                           wb_allowin,
    output logic                           rf_we,
    output logic [cpu_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [cpu_pkg::xlen-1:0]       rf_wdata,
    output logic [cpu_pkg::xlen-1:0]       debug_wb_pc,
    output logic [3:0]                     debug_wb_rf_wen,
    output logic [4:0]                     debug_wb_rf_wnum,
    output logic [cpu_pkg::xlen-1:0]       debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic                  wb_valid;
    logic [xlen-1:0]       wb_pc;
    logic [reg_addr_w-1:0] wnum;
    logic [xlen-1:0]       wdata;

    // last stage, drains every cycle
    assign wb_allowin = 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid && wb_allowin) begin
            wb_pc <= mem_pc;
            wnum  <= mem_wnum;
            wdata <= mem_is_load ? data_sram_rdata : mem_result;
        end
    end

    assign rf_we    = wb_valid && (wnum != '0);
    assign rf_waddr = rf_we ? wnum : '0;
    assign rf_wdata = wdata;

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = wdata;

endmodule

`default_nettype wire

/* hdl/memory_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module memory_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           exe_valid,
    input  logic [cpu_pkg::xlen-1:0]       exe_pc,
    input  logic [cpu_pkg::xlen-1:0]       exe_result,
    input  logic                           exe_is_load,
    input  logic [cpu_pkg::reg_addr_w-1:0] exe_wnum,
    input  logic                           wb_allowin,
    output logic                           mem_allowin,
    output logic                           mem_valid,
    output logic [cpu_pkg::xlen-1:0]       mem_pc,
    output logic [cpu_pkg::xlen-1:0]       mem_result,
    output logic                           mem_is_load,
    output logic [cpu_pkg::reg_addr_w-1:0] mem_wnum
);
    import cpu_pkg::*;

    logic [reg_addr_w-1:0] wnum;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid && mem_allowin) begin
            mem_pc      <= exe_pc;
            mem_result  <= exe_result;
            mem_is_load <= exe_is_load;
            wnum        <= exe_wnum;
        end
    end

    // load data is back in a fixed cycle, so the item is always ready
    assign mem_allowin = !mem_valid || wb_allowin;
    assign mem_wnum    = mem_valid ? wnum : '0;

endmodule

`default_nettype wire

/* execute/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           id_valid,
    input  logic [cpu_pkg::xlen-1:0]       id_pc,
    input  cpu_pkg::alu_op_t               id_alu_op,
    input  logic [cpu_pkg::xlen-1:0]       id_src_a,
    input  logic [cpu_pkg::xlen-1:0]       id_src_b,
    input  logic [cpu_pkg::xlen-1:0]       id_store_data,
    input  logic                           id_is_load,
    input  logic                           id_is_store,
    input  logic [cpu_pkg::reg_addr_w-1:0] id_wnum,
    input  logic                           mem_allowin,
    output logic                           exe_allowin,
    output logic                           exe_valid,
    output logic [cpu_pkg::xlen-1:0]       exe_pc,
    output logic [cpu_pkg::xlen-1:0]       exe_result,
    output logic                           exe_is_load,
    output logic [cpu_pkg::reg_addr_w-1:0] exe_wnum,
    output logic                           data_sram_en,
    output logic [3:0]                     data_sram_wen,
    output logic [cpu_pkg::xlen-1:0]       data_sram_addr,
    output logic [cpu_pkg::xlen-1:0]       data_sram_wdata
);
    import cpu_pkg::*;

    alu_op_t               alu_op;
    logic [xlen-1:0]       src_a;
    logic [xlen-1:0]       src_b;
    logic [xlen-1:0]       store_data;
    logic                  is_store;
    logic [reg_addr_w-1:0] wnum;
    logic                  to_mem;

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else if (exe_allowin) begin
            exe_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid && exe_allowin) begin
            exe_pc      <= id_pc;
            alu_op      <= id_alu_op;
            src_a       <= id_src_a;
            src_b       <= id_src_b;
            store_data  <= id_store_data;
            exe_is_load <= id_is_load;
            is_store    <= id_is_store;
            wnum        <= id_wnum;
        end
    end

    // ------------------------------
    // alu
    // ------------------------------
    always_comb begin
        case (alu_op)
            alu_add: exe_result = src_a + src_b;
            alu_sub: exe_result = src_a - src_b;
            alu_and: exe_result = src_a & src_b;
            alu_or:  exe_result = src_a | src_b;
            alu_xor: exe_result = src_a ^ src_b;
            alu_slt: exe_result = {31'd0, $signed(src_a) < $signed(src_b)};
            alu_lui: exe_result = {src_b[15:0], 16'h0000};
            default: exe_result = '0;
        endcase
    end

    assign exe_allowin = !exe_valid || mem_allowin;
    assign exe_wnum    = exe_valid ? wnum : '0;

    // request goes out as the item moves on to memory
    assign to_mem          = exe_valid && mem_allowin;
    assign data_sram_en    = to_mem && (exe_is_load || is_store);
    assign data_sram_wen   = {4{to_mem && is_store}};
    assign data_sram_addr  = exe_result;
    assign data_sram_wdata = store_data;

endmodule

`default_nettype wire

/* decode/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           if_valid,
    input  logic [cpu_pkg::xlen-1:0]       if_pc,
    input  logic [cpu_pkg::xlen-1:0]       if_inst,
    input  logic                           exe_allowin,
    input  logic                           rf_we,
    input  logic [cpu_pkg::reg_addr_w-1:0] rf_waddr,
    input  logic [cpu_pkg::xlen-1:0]       rf_wdata,
    input  logic [cpu_pkg::reg_addr_w-1:0] exe_wnum,
    input  logic [cpu_pkg::reg_addr_w-1:0] mem_wnum,
    input  logic [cpu_pkg::reg_addr_w-1:0] wb_wnum,
    output logic                           id_allowin,
    output logic                           id_valid,
    output logic [cpu_pkg::xlen-1:0]       id_pc,
    output cpu_pkg::alu_op_t               id_alu_op,
    output logic [cpu_pkg::xlen-1:0]       id_src_a,
    output logic [cpu_pkg::xlen-1:0]       id_src_b,
    output logic [cpu_pkg::xlen-1:0]       id_store_data,
    output logic                           id_is_load,
    output logic                           id_is_store,
    output logic [cpu_pkg::reg_addr_w-1:0] id_wnum
);
    import cpu_pkg::*;

    logic                  id_full;
    logic [xlen-1:0]       inst;
    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm_sext;
    logic [xlen-1:0]       imm_zext;
    logic [xlen-1:0]       rs_value;
    logic [xlen-1:0]       rt_value;
    logic                  use_rs;
    logic                  use_rt;
    logic                  hazard;
    logic                  id_ready;

    // register waiting on an older write still in the pipe
    function automatic logic is_pending(input logic [reg_addr_w-1:0] src,
                                        input logic [reg_addr_w-1:0] exe_dst,
                                        input logic [reg_addr_w-1:0] mem_dst,
                                        input logic [reg_addr_w-1:0] wb_dst);
        return (src != '0) && (src == exe_dst || src == mem_dst || src == wb_dst);
    endfunction

    // ------------------------------
    // pipeline register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            id_full <= 1'b0;
        end else if (id_allowin) begin
            id_full <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && id_allowin) begin
            id_pc <= if_pc;
            inst  <= if_inst;
        end
    end

    reg_file reg_file_i (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rs_value),
        .rdata2 (rt_value),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    // ------------------------------
    // decode
    // ------------------------------
    assign opcode   = inst[31:26];
    assign rs       = inst[25:21];
    assign rt       = inst[20:16];
    assign rd       = inst[15:11];
    assign funct    = inst[5:0];
    assign imm_sext = {{16{inst[15]}}, inst[15:0]};
    assign imm_zext = {16'h0000, inst[15:0]};

    always_comb begin
        id_alu_op   = alu_add;
        id_src_b    = rt_value;
        id_is_load  = 1'b0;
        id_is_store = 1'b0;
        id_wnum     = '0;
        use_rs      = 1'b0;
        use_rt      = 1'b0;
        case (opcode)
            op_special: begin
                id_wnum = rd;
                use_rs  = 1'b1;
                use_rt  = 1'b1;
                case (funct)
                    fn_addu: id_alu_op = alu_add;
                    fn_subu: id_alu_op = alu_sub;
                    fn_and:  id_alu_op = alu_and;
                    fn_or:   id_alu_op = alu_or;
                    fn_xor:  id_alu_op = alu_xor;
                    fn_slt:  id_alu_op = alu_slt;
                    default: begin
                        // unsupported funct retires as a no-op
                        id_wnum = '0;
                        use_rs  = 1'b0;
                        use_rt  = 1'b0;
                    end
                endcase
            end
            op_addiu: begin
                id_src_b = imm_sext;
                id_wnum  = rt;
                use_rs   = 1'b1;
            end
            op_ori: begin
                id_alu_op = alu_or;
                id_src_b  = imm_zext;
                id_wnum   = rt;
                use_rs    = 1'b1;
            end
            op_lui: begin
                id_alu_op = alu_lui;
                id_src_b  = imm_zext;
                id_wnum   = rt;
            end
            op_lw: begin
                id_src_b   = imm_sext;
                id_is_load = 1'b1;
                id_wnum    = rt;
                use_rs     = 1'b1;
            end
            op_sw: begin
                id_src_b    = imm_sext;
                id_is_store = 1'b1;
                use_rs      = 1'b1;
                use_rt      = 1'b1;
            end
            default: ;
        endcase
    end

    assign id_src_a      = rs_value;
    assign id_store_data = rt_value;

    // interlock until the producer has left writeback
    assign hazard     = (use_rs && is_pending(rs, exe_wnum, mem_wnum, wb_wnum)) ||
                        (use_rt && is_pending(rt, exe_wnum, mem_wnum, wb_wnum));
    assign id_ready   = !hazard;
    assign id_allowin = !id_full || (id_ready && exe_allowin);
    assign id_valid   = id_full && id_ready;

endmodule

`default_nettype wire

/* fetch/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     id_allowin,
    input  logic [cpu_pkg::xlen-1:0] inst_sram_rdata,
    output logic                     if_valid,
    output logic [cpu_pkg::xlen-1:0] if_pc,
    output logic [cpu_pkg::xlen-1:0] if_inst,
    output logic                     inst_sram_en,
    output logic [cpu_pkg::xlen-1:0] inst_sram_addr
);
    import cpu_pkg::*;

    logic            running;
    logic            if_allowin;
    logic [xlen-1:0] next_pc;
    logic            inst_held;
    logic [xlen-1:0] inst_buf;

    assign if_allowin     = !if_valid || id_allowin;
    assign inst_sram_en   = running && if_allowin;
    assign inst_sram_addr = next_pc;

    // fresh word straight from the sram, held copy while stalled
    assign if_inst = inst_held ? inst_buf : inst_sram_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            running   <= 1'b0;
            if_valid  <= 1'b0;
            next_pc   <= reset_pc;
            inst_held <= 1'b0;
        end else begin
            running <= 1'b1;
            if (inst_sram_en) begin
                if_valid  <= 1'b1;
                next_pc   <= next_pc + 32'd4;
                inst_held <= 1'b0;
            end else if (if_valid) begin
                // decode is stalled, word must be kept
                inst_held <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_sram_en) begin
            if_pc <= next_pc;
        end
        if (!inst_sram_en && if_valid && !inst_held) begin
            inst_buf <= inst_sram_rdata;
        end
    end

endmodule

`default_nettype wire

/* decode/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [0:31];

    // $0 is never written
    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

`default_nettype wire

/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // ------------------------------
    // widths and reset vector
    // ------------------------------
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'hbfc00000;

    // ------------------------------
    // opcodes
    // ------------------------------
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special funct field
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    // ------------------------------
    // alu operations
    // ------------------------------
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui
    } alu_op_t;

endpackage

`default_nettype wire
